//--- bench/map_patterns.txt
# A vga_h vga_v expected_addr   (screen pixel, decimal ROM address one edge later)
# F en p1_h p1_v p2_h p2_v jump1 jump2 led_hex   (full frame, grid positions, led bits 9..0)
# Ceiling, its corner with the left boundary and its bottom edge.
A 100 4 71090
A 4 4 71042
A 100 18 73330
A 100 20 12900
# Boundaries.
A 10 200 32310
A 18 200 32314
A 20 200 12900
A 630 200 32310
# Rivers over the floor, and the floor itself.
A 320 464 21450
A 320 470 22410
A 320 472 72480
A 430 462 22780
A 200 464 71140
# Walls, including the wall_3 and wall_4 overlap.
A 40 370 69820
A 41 371 69820
A 40 362 12900
A 200 280 70730
A 340 192 70485
A 618 100 71239
A 620 100 16305
A 560 430 71365
# Doors and empty space.
A 520 60 32010
A 580 60 32042
A 100 100 12900
# Both players standing on the floor.
F 1 30 214 60 214 0 0 00C
# Midair, once with jump zero and once jumping.
F 1 30 150 60 150 0 2 010
F 1 30 150 60 214 1 0 008
# Player 1 inside wall_1.
F 1 50 178 60 214 0 0 019
# Diamond and button, player 2 standing on wall_1.
F 1 190 205 98 166 0 0 0D8
# Player 1 in the blue river.
F 1 220 222 60 214 0 0 20C
# Both players at their doors on top of wall_5.
F 1 255 32 285 32 0 0 10C
# Disabled frame keeps the previous results.
F 0 220 222 50 178 0 0 10C
F 1 30 214 60 214 0 0 00C

//--- bench/map_checks.svh
`ifndef MAP_CHECKS_SVH
`define MAP_CHECKS_SVH

int addr_errors  = 0;
int flag_errors  = 0;
int led_errors   = 0;
int other_errors = 0;  // File problems and unreadable records.
int check_count  = 0;

task automatic check_addr(
    input string     name,
    input rom_addr_t expected,
    input rom_addr_t actual
);
    check_count++;
    if (actual !== expected) begin
        addr_errors++;
        $display("FAILED at %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
    end
endtask

task automatic check_flag(
    input string name,
    input logic  expected,
    input logic  actual
);
    check_count++;
    if (actual !== expected) begin
        flag_errors++;
        $display("FAILED at %0t: %s expected %b, actual %b", $time, name, expected, actual);
    end
endtask

task automatic check_led(
    input string       name,
    input logic [15:0] expected,
    input logic [15:0] actual
);
    check_count++;
    if (actual !== expected) begin
        led_errors++;
        $display("FAILED at %0t: %s expected %h, actual %h", $time, name, expected, actual);
    end
endtask

`endif

//--- bench/tb_map_top.sv
`timescale 1ns/1ps
`include "map_config.svh"

module tb_map_top;
    import map_pkg::*;

    localparam string  PATTERN_FILE = "bench/map_patterns.txt";
    localparam int     FRAME_CYCLES = `MAP_H_VISIBLE * `MAP_V_VISIBLE;
    localparam coord_t IDLE_H       = coord_t'(100);  // Grid pixel (50,50) has no terrain.
    localparam coord_t IDLE_V       = coord_t'(100);

    logic        clk;
    logic        rst_n;
    logic        en;
    coord_t      vga_h;
    coord_t      vga_v;
    coord_t      p1_h;
    coord_t      p1_v;
    coord_t      p2_h;
    coord_t      p2_v;
    jump_t       player_jump;
    jump_t       player2_jump;
    rom_addr_t   addr;
    logic        p1_collision;
    logic        p2_collision;
    logic        p1_land;
    logic        p2_land;
    logic        should_down;
    logic        should_down2;
    logic        diamond_touch;
    logic        button_touch;
    logic        clear;
    logic        fail;
    logic [15:0] led;

    int cycles      = 0;
    int cycle_limit = 2147483647;  // Replaced once the records are counted.
    int n_addr;
    int n_frame;
    int errors_total;

    `include "map_checks.svh"

    map_top map_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .vga_h         (vga_h),
        .vga_v         (vga_v),
        .p1_h          (p1_h),
        .p1_v          (p1_v),
        .p2_h          (p2_h),
        .p2_v          (p2_v),
        .player_jump   (player_jump),
        .player2_jump  (player2_jump),
        .addr          (addr),
        .p1_collision  (p1_collision),
        .p2_collision  (p2_collision),
        .p1_land       (p1_land),
        .p2_land       (p2_land),
        .should_down   (should_down),
        .should_down2  (should_down2),
        .diamond_touch (diamond_touch),
        .button_touch  (button_touch),
        .clear         (clear),
        .fail          (fail),
        .led           (led)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period.
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles.", cycle_limit);
        $display("sim failed");
        $finish;
    end

    // Bit order of expected follows led.
    task automatic check_frame_results(input logic [15:0] expected);
        check_flag("p1_collision", expected[0], p1_collision);
        check_flag("p2_collision", expected[1], p2_collision);
        check_flag("p1_land", expected[2], p1_land);
        check_flag("p2_land", expected[3], p2_land);
        check_flag("should_down", expected[4], should_down);
        check_flag("should_down2", expected[5], should_down2);
        check_flag("diamond_touch", expected[6], diamond_touch);
        check_flag("button_touch", expected[7], button_touch);
        check_flag("clear", expected[8], clear);
        check_flag("fail", expected[9], fail);
        check_led("led", expected, led);
    endtask

    task automatic check_pixel_addr(input coord_t h, input coord_t v, input rom_addr_t expected);
        @(negedge clk);
        vga_h = h;
        vga_v = v;
        @(negedge clk);  // The rising edge in between registers the address.
        check_addr("addr", expected, addr);
    endtask

    task automatic scan_frame(
        input logic        frame_en,
        input coord_t      h1,
        input coord_t      v1,
        input coord_t      h2,
        input coord_t      v2,
        input jump_t       j1,
        input jump_t       j2,
        input logic [15:0] expected
    );
        for (int v = 0; v < `MAP_V_VISIBLE; v++) begin
            for (int h = 0; h < `MAP_H_VISIBLE; h++) begin
                @(negedge clk);
                if (h == 0 && v == 0) begin
                    en           = frame_en;
                    p1_h         = h1;
                    p1_v         = v1;
                    p2_h         = h2;
                    p2_v         = v2;
                    player_jump  = j1;
                    player2_jump = j2;
                end
                vga_h = coord_t'(h);
                vga_v = coord_t'(v);
            end
        end
        @(negedge clk);  // The last pixel was sampled and the frame published.
        check_frame_results(expected);
        en    = 1'b0;
        vga_h = IDLE_H;   // Leave the frame-end pixel so nothing publishes twice.
        vga_v = IDLE_V;
    endtask

    task automatic scan_patterns(input bit run, output int addr_recs, output int frame_recs);
        int    fd;
        int    got;
        int    f0, f1, f2, f3, f4, f5, f6, f7;
        string line;
        byte   kind;
        addr_recs  = 0;
        frame_recs = 0;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the pattern file %s.", PATTERN_FILE);
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2) continue;
            kind = line[0];
            if (kind == "#") continue;
            if (kind == "A") begin
                got = $sscanf(line.substr(1, line.len() - 1), "%d %d %d", f0, f1, f2);
                if (got == 3) begin
                    addr_recs++;
                    if (run) check_pixel_addr(coord_t'(f0), coord_t'(f1), rom_addr_t'(f2));
                end else if (run) begin
                    $display("Pattern line could not be read: %s", line);
                    other_errors++;
                end
            end else if (kind == "F") begin
                got = $sscanf(line.substr(1, line.len() - 1), "%d %d %d %d %d %d %d %h",
                              f0, f1, f2, f3, f4, f5, f6, f7);
                if (got == 8) begin
                    frame_recs++;
                    if (run) begin
                        scan_frame(f0 != 0, coord_t'(f1), coord_t'(f2), coord_t'(f3),
                                   coord_t'(f4), jump_t'(f5), jump_t'(f6), f7[15:0]);
                    end
                end else if (run) begin
                    $display("Pattern line could not be read: %s", line);
                    other_errors++;
                end
            end else if (run) begin
                $display("Pattern line has an unknown record type: %s", line);
                other_errors++;
            end
        end
        $fclose(fd);
    endtask

    initial begin
        rst_n        = 1'b0;
        en           = 1'b0;
        vga_h        = IDLE_H;
        vga_v        = IDLE_V;
        p1_h         = '0;
        p1_v         = '0;
        p2_h         = '0;
        p2_v         = '0;
        player_jump  = '0;
        player2_jump = '0;

        scan_patterns(1'b0, n_addr, n_frame);
        cycle_limit = n_addr + n_frame * FRAME_CYCLES + 1000;
        if (other_errors == 0 && n_addr + n_frame == 0) begin
            $display("The pattern file holds no records.");
            other_errors++;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_addr("addr", rom_addr_t'(`MAP_BG_ADDR), addr);  // Reset values.
        check_frame_results(16'h0000);

        if (other_errors == 0) begin
            scan_patterns(1'b1, n_addr, n_frame);
        end

        errors_total = addr_errors + flag_errors + led_errors + other_errors;
        $display("Checks %0d, errors: addr %0d, flag %0d, led %0d, other %0d",
                 check_count, addr_errors, flag_errors, led_errors, other_errors);
        if (errors_total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- common/map_config.svh
`ifndef MAP_CONFIG_SVH
`define MAP_CONFIG_SVH

// Visible VGA area in screen pixels.
`define MAP_H_VISIBLE 640
`define MAP_V_VISIBLE 480

// Screen pixels are halved onto the 320x240 game grid.
`define MAP_GRID_SHIFT 1

`define MAP_ROM_ROW 320    // Words per row of the sprite ROM image.

`define MAP_BG_ADDR 12900  // Shown where no terrain is drawn.

// Player bounding box in grid units.
`define MAP_PLAYER_W 10
`define MAP_PLAYER_H 16

// Diamond pickup, half-open ranges on the grid.
`define MAP_DIAMOND_H0 194
`define MAP_DIAMOND_H1 206
`define MAP_DIAMOND_V0 203
`define MAP_DIAMOND_V1 220

// Floor button, half-open ranges on the grid.
`define MAP_BUTTON_H0 100
`define MAP_BUTTON_H1 105
`define MAP_BUTTON_V0 177
`define MAP_BUTTON_V1 182

`endif

//--- common/map_pkg.sv
package map_pkg;

    typedef logic [9:0]  coord_t;     // Pixel or grid coordinate.
    typedef logic [16:0] rom_addr_t;  // Sprite ROM word address.
    typedef logic [3:0]  pstate_t;    // Player animation state.
    typedef logic [1:0]  jump_t;      // Jump phase, zero when the player is not jumping.

    typedef struct packed {
        coord_t pivot_h;      // Top-left corner on the game grid.
        coord_t pivot_v;
        coord_t width;
        coord_t height;
        coord_t mem_pivot_h;  // Where the sprite starts inside the ROM image.
        coord_t mem_pivot_v;
    } rect_t;

    // Listed in drawing priority, the first entry wins an overlap.
    typedef enum logic [3:0] {
        TK_CEILING, TK_RED_RIVER, TK_BLUE_RIVER, TK_FLOOR,
        TK_LEFT_BOUNDARY, TK_RIGHT_BOUNDARY,
        TK_WALL_1, TK_WALL_2, TK_WALL_3, TK_WALL_4, TK_WALL_5, TK_WALL_6,
        TK_RED_DOOR, TK_BLUE_DOOR
    } terrain_kind_t;

    localparam int TERRAIN_COUNT = 14;

    localparam rect_t TERRAIN_TABLE [TERRAIN_COUNT] = '{
        '{10'd0,   10'd0,   10'd320, 10'd10,  10'd0,   10'd220},  // Ceiling.
        '{10'd150, 10'd230, 10'd40,  10'd6,   10'd0,   10'd65},   // Red river.
        '{10'd210, 10'd230, 10'd40,  10'd6,   10'd55,  10'd70},   // Blue river.
        '{10'd0,   10'd230, 10'd320, 10'd10,  10'd0,   10'd220},  // Floor.
        '{10'd0,   10'd0,   10'd10,  10'd240, 10'd305, 10'd0},    // Left boundary.
        '{10'd310, 10'd0,   10'd10,  10'd240, 10'd305, 10'd0},    // Right boundary.
        '{10'd10,  10'd182, 10'd230, 10'd8,   10'd50,  10'd215},
        '{10'd90,  10'd139, 10'd220, 10'd8,   10'd0,   10'd220},
        '{10'd85,  10'd96,  10'd185, 10'd8,   10'd0,   10'd220},
        '{10'd160, 10'd89,  10'd50,  10'd8,   10'd0,   10'd220},
        '{10'd110, 10'd48,  10'd200, 10'd8,   10'd0,   10'd220},
        '{10'd275, 10'd210, 10'd35,  10'd20,  10'd0,   10'd218},
        '{10'd250, 10'd19,  10'd23,  10'd29,  10'd0,   10'd89},   // Red door.
        '{10'd280, 10'd19,  10'd23,  10'd29,  10'd32,  10'd89}    // Blue door.
    };

endpackage

//--- obj_state/obj_state_ctrl.sv
`timescale 1ns/1ps
`include "map_config.svh"

module obj_state_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             en,
    input  map_pkg::coord_t  vga_h,
    input  map_pkg::coord_t  vga_v,
    input  map_pkg::coord_t  p1_h,
    input  map_pkg::coord_t  p1_v,
    input  map_pkg::coord_t  p2_h,
    input  map_pkg::coord_t  p2_v,
    input  map_pkg::jump_t   player_jump,
    input  map_pkg::jump_t   player2_jump,
    output logic             p1_collision,
    output logic             p2_collision,
    output logic             p1_land,
    output logic             p2_land,
    output logic             should_down,
    output logic             should_down2,
    output logic             diamond_touch,
    output logic             button_touch,
    output logic             clear,
    output logic             fail,
    output logic [15:0]      led
);
    import map_pkg::*;

    coord_t                   grid_h;
    coord_t                   grid_v;
    logic [TERRAIN_COUNT-1:0] hit;
    logic                     visible;
    logic                     live;
    logic                     frame_end;
    logic                     solid;
    logic                     ground;
    logic                     p1_in;
    logic                     p2_in;
    logic                     p1_below;
    logic                     p2_below;
    logic                     diamond_px;
    logic                     button_px;
    logic [8:0]               pix;   // Per-pixel events, same bit order as acc.
    logic [8:0]               acc;   // col1, col2, land1, land2, diamond, button, fail, door1, door2.
    logic [8:0]               nxt;

    function automatic logic in_span(coord_t g, coord_t p, coord_t size);
        return (g >= p) && (g < p + size);
    endfunction

    assign grid_h = vga_h >> `MAP_GRID_SHIFT;
    assign grid_v = vga_v >> `MAP_GRID_SHIFT;

    for (genvar i = 0; i < TERRAIN_COUNT; i++) begin : g_terrain
        terrain u_terrain (
            .grid_h (grid_h),
            .grid_v (grid_v),
            .rect   (TERRAIN_TABLE[i]),
            .hit    (hit[i]),
            .addr   ()
        );
    end

    assign visible   = (vga_h < coord_t'(`MAP_H_VISIBLE)) && (vga_v < coord_t'(`MAP_V_VISIBLE));
    assign live      = en && visible;  // Blanking pixels never count.
    assign frame_end = (vga_h == coord_t'(`MAP_H_VISIBLE - 1))
                    && (vga_v == coord_t'(`MAP_V_VISIBLE - 1));

    assign solid  = hit[TK_LEFT_BOUNDARY] || hit[TK_RIGHT_BOUNDARY] || (|hit[TK_WALL_6:TK_WALL_1]);
    assign ground = hit[TK_FLOOR] || hit[TK_RED_RIVER] || hit[TK_BLUE_RIVER]
                 || (|hit[TK_WALL_6:TK_WALL_1]);

    assign p1_in = in_span(grid_h, p1_h, coord_t'(`MAP_PLAYER_W))
                && in_span(grid_v, p1_v, coord_t'(`MAP_PLAYER_H));
    assign p2_in = in_span(grid_h, p2_h, coord_t'(`MAP_PLAYER_W))
                && in_span(grid_v, p2_v, coord_t'(`MAP_PLAYER_H));

    // The feet probe is the grid row right under the box.
    assign p1_below = in_span(grid_h, p1_h, coord_t'(`MAP_PLAYER_W))
                   && (grid_v == p1_v + coord_t'(`MAP_PLAYER_H));
    assign p2_below = in_span(grid_h, p2_h, coord_t'(`MAP_PLAYER_W))
                   && (grid_v == p2_v + coord_t'(`MAP_PLAYER_H));

    assign diamond_px = in_span(grid_h, coord_t'(`MAP_DIAMOND_H0),
                                coord_t'(`MAP_DIAMOND_H1 - `MAP_DIAMOND_H0))
                     && in_span(grid_v, coord_t'(`MAP_DIAMOND_V0),
                                coord_t'(`MAP_DIAMOND_V1 - `MAP_DIAMOND_V0));
    assign button_px  = in_span(grid_h, coord_t'(`MAP_BUTTON_H0),
                                coord_t'(`MAP_BUTTON_H1 - `MAP_BUTTON_H0))
                     && in_span(grid_v, coord_t'(`MAP_BUTTON_V0),
                                coord_t'(`MAP_BUTTON_V1 - `MAP_BUTTON_V0));

    assign pix[0] = p1_in && solid;
    assign pix[1] = p2_in && solid;
    assign pix[2] = p1_below && ground;
    assign pix[3] = p2_below && ground;
    assign pix[4] = (p1_in || p2_in) && diamond_px;  // Either player picks up the diamond.
    assign pix[5] = (p1_in || p2_in) && button_px;
    assign pix[6] = (p1_in && hit[TK_BLUE_RIVER]) || (p2_in && hit[TK_RED_RIVER]);
    assign pix[7] = p1_in && hit[TK_RED_DOOR];   // Fire player at its own door.
    assign pix[8] = p2_in && hit[TK_BLUE_DOOR];  // Water player at its own door.

    assign nxt = acc | (pix & {9{live}});  // Includes the frame's last pixel at publish time.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (frame_end) begin
            acc <= '0;
        end else begin
            acc <= nxt;
        end
    end

    // Results change only at frame end with the block enabled.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p1_collision  <= 1'b0;
            p2_collision  <= 1'b0;
            p1_land       <= 1'b0;
            p2_land       <= 1'b0;
            should_down   <= 1'b0;
            should_down2  <= 1'b0;
            diamond_touch <= 1'b0;
            button_touch  <= 1'b0;
            fail          <= 1'b0;
            clear         <= 1'b0;
        end else if (frame_end && en) begin
            p1_collision  <= nxt[0];
            p2_collision  <= nxt[1];
            p1_land       <= nxt[2];
            p2_land       <= nxt[3];
            should_down   <= !nxt[2] && (player_jump == '0);   // Falls only when not jumping.
            should_down2  <= !nxt[3] && (player2_jump == '0);
            diamond_touch <= nxt[4];
            button_touch  <= nxt[5];
            fail          <= nxt[6];
            clear         <= nxt[7] && nxt[8];
        end
    end

    assign led = {6'b0, fail, clear, button_touch, diamond_touch, should_down2, should_down,
                  p2_land, p1_land, p2_collision, p1_collision};

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing -f sources.f --top-module tb_map_top -o tb_map_top \
    > build.log 2>&1 \
    && ./obj_dir/tb_map_top > sim.log 2>&1 \
    || { echo "Build or run error, see build.log and sim.log."; exit 1; }

cat sim.log
grep -qx "sim passed" sim.log && exit 0 || exit 1

//--- sources.f
+incdir+common
+incdir+bench
common/map_pkg.sv
terrain/terrain.sv
terrain/terrain_layer.sv
obj_state/obj_state_ctrl.sv
verilog/map_top.sv
bench/tb_map_top.sv

//--- terrain/terrain.sv
`timescale 1ns/1ps
`include "map_config.svh"

module terrain (
    input  map_pkg::coord_t    grid_h,
    input  map_pkg::coord_t    grid_v,
    input  map_pkg::rect_t     rect,
    output logic               hit,
    output map_pkg::rom_addr_t addr
);
    import map_pkg::*;

    logic [10:0] end_h;
    logic [10:0] end_v;
    rom_addr_t   col;
    rom_addr_t   row;

    assign end_h = {1'b0, rect.pivot_h} + {1'b0, rect.width};   // Spare bit keeps the sum exact.
    assign end_v = {1'b0, rect.pivot_v} + {1'b0, rect.height};

    assign hit = (grid_h >= rect.pivot_h) && ({1'b0, grid_h} < end_h) &&
                 (grid_v >= rect.pivot_v) && ({1'b0, grid_v} < end_v);

    // Offset inside the rectangle, moved to where the sprite sits in the ROM image.
    assign col = rom_addr_t'(grid_h) - rom_addr_t'(rect.pivot_h)
               + rom_addr_t'(rect.mem_pivot_h);
    assign row = rom_addr_t'(grid_v) - rom_addr_t'(rect.pivot_v)
               + rom_addr_t'(rect.mem_pivot_v);

    assign addr = col + row * rom_addr_t'(`MAP_ROM_ROW);  // Only meaningful while hit is high.

endmodule

//--- terrain/terrain_layer.sv
`timescale 1ns/1ps
`include "map_config.svh"

module terrain_layer (
    input  logic               clk,
    input  logic               rst_n,
    input  map_pkg::coord_t    vga_h,
    input  map_pkg::coord_t    vga_v,
    output map_pkg::rom_addr_t addr
);
    import map_pkg::*;

    coord_t                   grid_h;
    coord_t                   grid_v;
    logic [TERRAIN_COUNT-1:0] hit;
    rom_addr_t                t_addr [TERRAIN_COUNT];
    rom_addr_t                next_addr;

    assign grid_h = vga_h >> `MAP_GRID_SHIFT;  // Two screen pixels per grid cell.
    assign grid_v = vga_v >> `MAP_GRID_SHIFT;

    for (genvar i = 0; i < TERRAIN_COUNT; i++) begin : g_terrain
        terrain u_terrain (
            .grid_h (grid_h),
            .grid_v (grid_v),
            .rect   (TERRAIN_TABLE[i]),
            .hit    (hit[i]),
            .addr   (t_addr[i])
        );
    end

    // Walk from the lowest priority up so the first table entry that hits is the one kept.
    always_comb begin
        next_addr = rom_addr_t'(`MAP_BG_ADDR);
        for (int i = TERRAIN_COUNT - 1; i >= 0; i--) begin
            if (hit[i]) begin
                next_addr = t_addr[i];
            end
        end
    end

    // One cycle from pixel to address.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr <= rom_addr_t'(`MAP_BG_ADDR);
        end else begin
            addr <= next_addr;
        end
    end

endmodule

//--- verilog/map_top.sv
`timescale 1ns/1ps

module map_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  map_pkg::coord_t    vga_h,
    input  map_pkg::coord_t    vga_v,
    input  map_pkg::coord_t    p1_h,
    input  map_pkg::coord_t    p1_v,
    input  map_pkg::coord_t    p2_h,
    input  map_pkg::coord_t    p2_v,
    input  map_pkg::jump_t     player_jump,
    input  map_pkg::jump_t     player2_jump,
    output map_pkg::rom_addr_t addr,
    output logic               p1_collision,
    output logic               p2_collision,
    output logic               p1_land,
    output logic               p2_land,
    output logic               should_down,
    output logic               should_down2,
    output logic               diamond_touch,
    output logic               button_touch,
    output logic               clear,
    output logic               fail,
    output logic [15:0]        led
);

    // Sprite ROM address for every pixel of the scan.
    terrain_layer u_terrain_layer (
        .clk   (clk),
        .rst_n (rst_n),
        .vga_h (vga_h),
        .vga_v (vga_v),
        .addr  (addr)
    );

    // Per-frame player and object state.
    obj_state_ctrl u_obj_state_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .vga_h         (vga_h),
        .vga_v         (vga_v),
        .p1_h          (p1_h),
        .p1_v          (p1_v),
        .p2_h          (p2_h),
        .p2_v          (p2_v),
        .player_jump   (player_jump),
        .player2_jump  (player2_jump),
        .p1_collision  (p1_collision),
        .p2_collision  (p2_collision),
        .p1_land       (p1_land),
        .p2_land       (p2_land),
        .should_down   (should_down),
        .should_down2  (should_down2),
        .diamond_touch (diamond_touch),
        .button_touch  (button_touch),
        .clear         (clear),
        .fail          (fail),
        .led           (led)
    );

endmodule
